//--- rtl/overlay_pkg.sv
// overlay package: shared widths, pixel, video, fifo word, switch and segment types
package overlay_pkg;

  // ==========================================================================
  // widths and counts
  // ==========================================================================
  localparam int CHAN_W = 8;   // one colour channel
  localparam int SW_W   = 5;   // slide switches in use
  localparam int DIGITS = 6;   // seven-segment digits on the board
  localparam int DIM_W  = 12;  // measured width / height, three hex digits

  // one rgb pixel, 24 bits
  typedef struct packed {
    logic [CHAN_W-1:0] r;
    logic [CHAN_W-1:0] g;
    logic [CHAN_W-1:0] b;
  } rgb_t;

  // dvi receiver output bundle, 27 bits
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;     // active video
    rgb_t rgb;
  } video_t;

  // overlay word as stored in the pixel fifo, 32 bits
  typedef struct packed {
    logic [CHAN_W-1:0] alpha;  // 8'hff = overlay only
    rgb_t              rgb;
  } ovl_word_t;

  // registered switch controls
  typedef struct packed {
    logic pattern_pause;  // sw 4
    logic overlay_en;     // sw 1
    logic blank;          // sw 0
  } sw_ctrl_t;

  // segment lines, active low, a in bit 0
  typedef logic [6:0] seg7_t;

endpackage

//--- rtl/pattern_gen.sv
// test-pattern producer, writes a counting overlay word into the pixel fifo
`timescale 1ns/100ps

module pattern_gen #(
  parameter logic [overlay_pkg::CHAN_W-1:0] PATTERN_ALPHA = 8'h80
) (
  input  logic                  odck_to_overlay,
  input  logic                  hps_fpga_reset_n,
  input  logic                  pause_i,     // from switch register
  input  logic                  full_i,      // fifo back-pressure
  output logic                  wr_en_o,
  output overlay_pkg::ovl_word_t wr_data_o
);

  import overlay_pkg::*;

  // ==========================================================================
  // word index
  // ==========================================================================
  logic [2*CHAN_W-1:0] idx_q;  // 16 bit, wraps

  // write whenever there is room and the pattern runs
  assign wr_en_o = !full_i && !pause_i;

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      idx_q <= '0;
    end
    else if (wr_en_o)
    begin
      idx_q <= idx_q + 1'b1;  // advance only on an accepted write
    end
  end

  // ==========================================================================
  // word format
  // ==========================================================================
  // r ramps, g is its mirror, b steps once every 256 words
  always_comb
  begin
    wr_data_o.alpha = PATTERN_ALPHA;
    wr_data_o.rgb.r = idx_q[CHAN_W-1:0];
    wr_data_o.rgb.g = ~idx_q[CHAN_W-1:0];
    wr_data_o.rgb.b = idx_q[2*CHAN_W-1:CHAN_W];
  end

endmodule

//--- rtl/pixel_fifo.sv
// single-clock show-ahead fifo carrying overlay words from producer to mixer
`timescale 1ns/100ps

module pixel_fifo #(
  parameter int FIFO_DEPTH = 16  // power of two
) (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  logic                   wr_en_i,
  input  overlay_pkg::ovl_word_t wr_data_i,
  input  logic                   rd_en_i,
  output overlay_pkg::ovl_word_t rd_data_o,
  output logic                   full_o,
  output logic                   empty_o
);

  import overlay_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);  // pointer width

  ovl_word_t       mem [FIFO_DEPTH];  // storage
  logic [AW-1:0]   wr_ptr_q;          // wraps at depth
  logic [AW-1:0]   rd_ptr_q;
  logic [AW:0]     cnt_q;             // fill level 0..FIFO_DEPTH
  logic            wr_ok;
  logic            rd_ok;

  assign full_o  = (cnt_q == (AW+1)'(FIFO_DEPTH));
  assign empty_o = (cnt_q == '0);

  assign wr_ok = wr_en_i && !full_o;
  assign rd_ok = rd_en_i && !empty_o;

  // head word always on the output
  assign rd_data_o = mem[rd_ptr_q];

  // ==========================================================================
  // storage
  // ==========================================================================
  always_ff @(posedge odck_to_overlay)
  begin
    if (wr_ok)
    begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // ==========================================================================
  // pointers and fill count
  // ==========================================================================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_ok)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // idle or simultaneous push/pop
      endcase
    end
  end

  // producer must respect full, mixer must respect empty
  a_no_write_full: assert property (
    @(posedge odck_to_overlay) disable iff (!hps_fpga_reset_n)
    wr_en_i |-> !full_o
  );

  a_no_read_empty: assert property (
    @(posedge odck_to_overlay) disable iff (!hps_fpga_reset_n)
    rd_en_i |-> !empty_o
  );

endmodule

//--- rtl/overlay_mixer.sv
// overlay mixer that captures dvi video and alpha-blends fifo words onto active pixels
`timescale 1ns/100ps

module overlay_mixer (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  overlay_pkg::video_t    video_i,       // from dvi receiver
  input  logic                   overlay_en_i,
  input  logic                   blank_i,
  input  overlay_pkg::ovl_word_t ovl_i,         // fifo head word
  input  logic                   empty_i,
  output logic                   rd_en_o,       // pop strobe
  output overlay_pkg::video_t    cap_video_o,   // stage-1 copy for the status block
  output overlay_pkg::video_t    video_o,       // stage-2 output to the vga dac
  output logic                   blank_n_o
);

  import overlay_pkg::*;

  localparam int ACC_W = 2*CHAN_W + 1;  // room for the weighted sum

  video_t s1_q;       // captured input
  logic   blend_en;   // this stage-1 pixel takes an overlay word
  rgb_t   mix_rgb;    // blended or passed colour

  // per channel (ovl*a + vid*(256-a)) >> 8
  function automatic logic [CHAN_W-1:0] blend_chan(
    input logic [CHAN_W-1:0] ovl,
    input logic [CHAN_W-1:0] vid,
    input logic [CHAN_W-1:0] alpha
  );
    logic [ACC_W-1:0] acc;
    acc = ACC_W'(ovl) * ACC_W'(alpha)
        + ACC_W'(vid) * (ACC_W'(256) - ACC_W'(alpha));
    return acc[2*CHAN_W-1:CHAN_W];  // sum tops out at 255*256 so bit 16 stays clear
  endfunction

  // ==========================================================================
  // stage 1 input capture
  // ==========================================================================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      s1_q <= '0;
    end
    else
    begin
      s1_q <= video_i;  // syncs, de and colour together
    end
  end

  assign cap_video_o = s1_q;

  // pop only for an active pixel with overlay on and a word waiting
  assign blend_en = s1_q.de && overlay_en_i && !empty_i;
  assign rd_en_o  = blend_en;

  always_comb
  begin
    if (blend_en)
    begin
      mix_rgb.r = blend_chan(ovl_i.rgb.r, s1_q.rgb.r, ovl_i.alpha);
      mix_rgb.g = blend_chan(ovl_i.rgb.g, s1_q.rgb.g, ovl_i.alpha);
      mix_rgb.b = blend_chan(ovl_i.rgb.b, s1_q.rgb.b, ovl_i.alpha);
    end
    else
    begin
      mix_rgb = s1_q.rgb;  // untouched video
    end
  end

  // ==========================================================================
  // stage 2 output register
  // ==========================================================================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      video_o   <= '0;
      blank_n_o <= 1'b0;
    end
    else
    begin
      video_o.vsync <= s1_q.vsync;
      video_o.hsync <= s1_q.hsync;
      video_o.de    <= s1_q.de;
      video_o.rgb   <= mix_rgb;
      blank_n_o     <= s1_q.de && !blank_i;  // active-low dac blank
    end
  end

  // a popped head word must hold written data
  a_pop_word_known: assert property (
    @(posedge odck_to_overlay) disable iff (!hps_fpga_reset_n)
    rd_en_o |-> !$isunknown(ovl_i)
  );

endmodule

//--- rtl/board_status.sv
// board status: switch register, heartbeat led, sync led and frame size on hex digits
`timescale 1ns/100ps

module board_status #(
  parameter int HEARTBEAT_DIV = 25000000  // led 0 half period in clocks
) (
  input  logic                                          odck_to_overlay,
  input  logic                                          hps_fpga_reset_n,
  input  logic [overlay_pkg::SW_W-1:0]                  sw_i,
  input  overlay_pkg::video_t                           cap_video_i,
  input  logic                                          scdt_i,   // dvi sync detect
  output overlay_pkg::sw_ctrl_t                         sw_o,
  output logic [1:0]                                    led_o,
  output overlay_pkg::seg7_t [overlay_pkg::DIGITS-1:0]  hex_o
);

  import overlay_pkg::*;

  localparam int    HB_W     = $clog2(HEARTBEAT_DIV);
  localparam seg7_t SEG_ZERO = 7'h40;

  sw_ctrl_t                sw_q;
  logic [HB_W-1:0]         hb_cnt_q;     // heartbeat divider
  logic                    hb_led_q;
  logic                    scdt_q;
  logic                    de_d_q;       // previous de
  logic                    vs_d_q;       // previous vsync
  logic                    de_fall;
  logic                    vs_rise;
  logic [DIM_W-1:0]        pix_cnt_q;    // de cycles in current line
  logic [DIM_W-1:0]        line_cnt_q;   // active lines in current frame
  logic [DIM_W-1:0]        width_q;
  logic [DIM_W-1:0]        height_q;
  logic [4*DIGITS-1:0]     nibbles;
  seg7_t [DIGITS-1:0]      hex_d;
  seg7_t [DIGITS-1:0]      hex_q;

  // hex nibble to active-low segments
  function automatic seg7_t hex_to_seg(input logic [3:0] nib);
    seg7_t seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'ha: seg = 7'h08;
      4'hb: seg = 7'h03;
      4'hc: seg = 7'h46;
      4'hd: seg = 7'h21;
      4'he: seg = 7'h06;
      default: seg = 7'h0e;  // f
    endcase
    return seg;
  endfunction

  // ==========================================================================
  // switches and leds
  // ==========================================================================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sw_q     <= '0;
      hb_cnt_q <= '0;
      hb_led_q <= 1'b0;
      scdt_q   <= 1'b0;
    end
    else
    begin
      sw_q.pattern_pause <= sw_i[4];
      sw_q.overlay_en    <= sw_i[1];
      sw_q.blank         <= sw_i[0];  // sw 3 and 2 unused here
      scdt_q             <= scdt_i;
      if (hb_cnt_q == HB_W'(HEARTBEAT_DIV - 1))
      begin
        hb_cnt_q <= '0;
        hb_led_q <= ~hb_led_q;  // blink
      end
      else
        hb_cnt_q <= hb_cnt_q + 1'b1;
    end
  end

  assign sw_o  = sw_q;
  assign led_o = {scdt_q, hb_led_q};

  // ==========================================================================
  // frame measurement
  // ==========================================================================
  assign de_fall = de_d_q && !cap_video_i.de;         // end of active line
  assign vs_rise = !vs_d_q && cap_video_i.vsync;      // start of new frame

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      de_d_q     <= 1'b0;
      vs_d_q     <= 1'b0;
      pix_cnt_q  <= '0;
      line_cnt_q <= '0;
      width_q    <= '0;
      height_q   <= '0;
    end
    else
    begin
      de_d_q <= cap_video_i.de;
      vs_d_q <= cap_video_i.vsync;
      if (cap_video_i.de)
        pix_cnt_q <= pix_cnt_q + 1'b1;
      else if (de_fall)
      begin
        width_q   <= pix_cnt_q;  // full line just ended
        pix_cnt_q <= '0;
      end
      if (vs_rise)
      begin
        height_q   <= line_cnt_q + DIM_W'(de_fall);
        line_cnt_q <= '0;
      end
      else if (de_fall)
        line_cnt_q <= line_cnt_q + 1'b1;
    end
  end

  // width on digits 5..3, height on 2..0
  assign nibbles = {width_q, height_q};

  always_comb
  begin
    for (int i = 0; i < DIGITS; i++)
      hex_d[i] = hex_to_seg(nibbles[4*i +: 4]);
  end

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      hex_q <= {DIGITS{SEG_ZERO}};
    else
      hex_q <= hex_d;  // one cycle behind the latch
  end

  assign hex_o = hex_q;

endmodule

//--- rtl/dvi_overlay_top.sv
// dvi overlay top: test pattern, pixel fifo, mixer and board status
`timescale 1ns/100ps

module dvi_overlay_top #(
  parameter int                             FIFO_DEPTH    = 16,
  parameter logic [overlay_pkg::CHAN_W-1:0] PATTERN_ALPHA = 8'h80,
  parameter int                             HEARTBEAT_DIV = 25000000
) (
  input  logic                                          odck_to_overlay,
  input  logic                                          hps_fpga_reset_n,
  input  overlay_pkg::video_t                           video_i,
  input  logic                                          scdt_i,
  input  logic [overlay_pkg::SW_W-1:0]                  sw_i,
  output overlay_pkg::video_t                           video_o,
  output logic                                          blank_n_o,
  output logic [1:0]                                    led_o,
  output overlay_pkg::seg7_t [overlay_pkg::DIGITS-1:0]  hex_o
);

  import overlay_pkg::*;

  // ==========================================================================
  // interconnect
  // ==========================================================================
  sw_ctrl_t  sw_ctrl;
  logic      fifo_wr_en;
  ovl_word_t fifo_wr_data;
  logic      fifo_full;
  logic      fifo_rd_en;
  ovl_word_t fifo_rd_data;
  logic      fifo_empty;
  video_t    cap_video;   // stage-1 video for measurement

  pattern_gen #(
    .PATTERN_ALPHA (PATTERN_ALPHA)
  ) i_pattern_gen (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .pause_i          (sw_ctrl.pattern_pause),
    .full_i           (fifo_full),
    .wr_en_o          (fifo_wr_en),
    .wr_data_o        (fifo_wr_data)
  );

  pixel_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_pixel_fifo (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .wr_en_i          (fifo_wr_en),
    .wr_data_i        (fifo_wr_data),
    .rd_en_i          (fifo_rd_en),
    .rd_data_o        (fifo_rd_data),
    .full_o           (fifo_full),
    .empty_o          (fifo_empty)
  );

  overlay_mixer i_overlay_mixer (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .video_i          (video_i),
    .overlay_en_i     (sw_ctrl.overlay_en),
    .blank_i          (sw_ctrl.blank),
    .ovl_i            (fifo_rd_data),
    .empty_i          (fifo_empty),
    .rd_en_o          (fifo_rd_en),
    .cap_video_o      (cap_video),
    .video_o          (video_o),
    .blank_n_o        (blank_n_o)
  );

  board_status #(
    .HEARTBEAT_DIV (HEARTBEAT_DIV)
  ) i_board_status (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .sw_i             (sw_i),
    .cap_video_i      (cap_video),
    .scdt_i           (scdt_i),
    .sw_o             (sw_ctrl),
    .led_o            (led_o),
    .hex_o            (hex_o)
  );

endmodule

//--- tb/tb_video_tasks.svh
// testbench video tasks: value check, blend model and per-cycle drive with output check
`ifndef TB_VIDEO_TASKS_SVH
`define TB_VIDEO_TASKS_SVH

// mismatch goes on one line with the running test name
task automatic check_equal(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    err_count++;
    $display("Error in %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
  end
endtask

// (overlay * a + video * (256 - a)) >> 8
function automatic logic [7:0] mix_channel(input int ovl, input int vid, input int alpha);
  int acc;
  acc = ovl * alpha + vid * (256 - alpha);
  return 8'(acc >> 8);
endfunction

// one clock: check the pixel due from two cycles ago, then apply the next input
task automatic drive_cycle(input video_t v);
  video_t    exp_v;
  ovl_word_t w;
  @(negedge odck_to_overlay);
  exp_v = exp_video_q.pop_front();
  check_equal("video_o", exp_v, vid_out);
  check_equal("blank_n_o", exp_blank_q.pop_front(), blank_n);
  check_equal("led 1", scdt, leds[1]);  // scdt seen one clock late
  vid_in = v;
  sw     = sw_set;
  scdt   = scdt_set;
  exp_v  = v;
  if (!sw_set[4])
    avail = FIFO_DEPTH;  // running producer keeps the fifo topped up
  if (v.de && sw_set[1] && avail > 0)
  begin
    w.alpha     = PATTERN_ALPHA;
    w.rgb.r     = model_idx[7:0];
    w.rgb.g     = ~model_idx[7:0];
    w.rgb.b     = model_idx[15:8];
    exp_v.rgb.r = mix_channel(w.rgb.r, v.rgb.r, w.alpha);
    exp_v.rgb.g = mix_channel(w.rgb.g, v.rgb.g, w.alpha);
    exp_v.rgb.b = mix_channel(w.rgb.b, v.rgb.b, w.alpha);
    model_idx++;  // next consecutive word
    avail--;
  end
  exp_video_q.push_back(exp_v);
  exp_blank_q.push_back(v.de && !sw_set[0]);
endtask

`endif

//--- tb/tb_dvi_overlay.sv
// testbench for the dvi overlay top, directed tests checked against a cycle model
`timescale 1ns/100ps

module tb_dvi_overlay;

  import overlay_pkg::*;

  localparam int         FIFO_DEPTH    = 16;     // dut default
  localparam logic [7:0] PATTERN_ALPHA = 8'h80;  // dut default
  localparam int         HB_DIV        = 10;
  localparam seg7_t      SEG_0         = 7'h40;  // a..f lit
  localparam seg7_t      SEG_2         = 7'h24;  // a b d e g
  localparam seg7_t      SEG_5         = 7'h12;  // a c d f g
  // reset, heartbeat, pass/blank, blend, pause, frame
  localparam int         RUN_CYCLES     = 4 + 40 + 42 + 42 + 77 + 216;
  localparam int         TIMEOUT_CYCLES = 2 * RUN_CYCLES;

  logic               odck_to_overlay;
  logic               hps_fpga_reset_n;
  video_t             vid_in;
  video_t             vid_out;
  logic               scdt;
  logic [SW_W-1:0]    sw;
  logic               blank_n;
  logic [1:0]         leds;
  seg7_t [DIGITS-1:0] hex_disp;

  // ==========================================================================
  // stimulus staging and model state
  // ==========================================================================
  logic [SW_W-1:0] sw_set;          // applied with the next pixel
  logic            scdt_set;
  video_t          exp_video_q[$];  // two cycles behind the inputs
  logic            exp_blank_q[$];
  logic [15:0]     model_idx;       // next overlay word
  int              avail;           // words left while paused
  int              up_cycles = 0;   // clocks since reset release
  int              cycle_cnt = 0;
  int              err_count = 0;
  int              test_errs;
  int              tests_ok  = 0;
  int              tests_bad = 0;
  string           cur_test;

  `include "tb_video_tasks.svh"

  dvi_overlay_top #(
    .HEARTBEAT_DIV (HB_DIV)
  ) i_dvi_overlay_top (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .video_i          (vid_in),
    .scdt_i           (scdt),
    .sw_i             (sw),
    .video_o          (vid_out),
    .blank_n_o        (blank_n),
    .led_o            (leds),
    .hex_o            (hex_disp)
  );

  initial
  begin
    odck_to_overlay = 1'b0;
    forever #50 odck_to_overlay = ~odck_to_overlay;  // 100 ns
  end

  always @(posedge odck_to_overlay)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (hps_fpga_reset_n)
      up_cycles <= up_cycles + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("run stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = err_count;
  endtask

  task automatic close_test;
    if (err_count == test_errs)
      tests_ok++;
    else
      tests_bad++;
    $display("test %s done, %0d errors", cur_test, err_count - test_errs);
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic test_reset;
    int i;
    start_test("reset");
    repeat (3) @(posedge odck_to_overlay);
    @(negedge odck_to_overlay);
    hps_fpga_reset_n = 1'b1;
    check_equal("video_o", 0, vid_out);
    check_equal("blank_n_o", 0, blank_n);
    check_equal("led_o", 0, leds);
    for (i = 0; i < DIGITS; i++)
      check_equal($sformatf("hex %0d", i), SEG_0, hex_disp[i]);
    repeat (2)
    begin
      exp_video_q.push_back('0);  // pipeline holds idle video
      exp_blank_q.push_back(1'b0);
    end
    close_test();
  endtask

  task automatic test_heartbeat;
    start_test("heartbeat");
    repeat (40)
    begin
      drive_cycle('0);
      check_equal("led 0", (up_cycles / HB_DIV) % 2, leds[0]);
    end
    close_test();
  endtask

  task automatic test_pass_blank;
    video_t v;
    int     i;
    start_test("pass_blank");
    sw_set = '0;  // overlay off
    for (i = 0; i < 40; i++)
    begin
      v         = 27'($urandom);  // random syncs, de and colour
      sw_set[0] = (i >= 20);      // blank second half
      scdt_set  = 1'($urandom);
      drive_cycle(v);
    end
    repeat (2) drive_cycle('0);
    close_test();
  endtask

  task automatic test_blend;
    video_t v;
    start_test("blend");
    sw_set = 5'b00010;  // overlay on, pattern running
    repeat (40)
    begin
      v     = '0;
      v.de  = ($urandom % 4) != 0;  // some inactive gaps
      v.rgb = 24'($urandom);
      drive_cycle(v);
    end
    repeat (2) drive_cycle('0);
    close_test();
  endtask

  task automatic test_pause;
    video_t v;
    int     i;
    start_test("pause");
    sw_set = 5'b10010;
    repeat (40) drive_cycle('0);  // fifo fills to depth
    for (i = 0; i < 35; i++)
    begin
      if (i == 24)
        sw_set = 5'b00010;  // release, refill over the idle gap
      v     = '0;
      v.de  = (i < 24) || (i >= 27);
      v.rgb = 24'($urandom);
      drive_cycle(v);
    end
    repeat (2) drive_cycle('0);
    close_test();
  endtask

  task automatic test_frame;
    video_t v;
    int     line;
    int     i;
    start_test("frame");
    sw_set = '0;
    v      = '0;
    repeat (2) drive_cycle(v);
    v.vsync = 1'b1;  // rise clears the line count
    repeat (2) drive_cycle(v);
    v.vsync = 1'b0;
    repeat (2) drive_cycle(v);
    for (line = 0; line < 5; line++)
      for (i = 0; i < 41; i++)
      begin
        v.de    = (i < 37);
        v.hsync = (i >= 38) && (i < 40);
        v.rgb   = v.de ? 24'($urandom) : 24'h0;
        drive_cycle(v);
      end
    v       = '0;
    v.vsync = 1'b1;  // closes the frame
    repeat (5) drive_cycle(v);
    check_equal("hex 5", SEG_0, hex_disp[5]);  // width 025
    check_equal("hex 4", SEG_2, hex_disp[4]);
    check_equal("hex 3", SEG_5, hex_disp[3]);
    check_equal("hex 2", SEG_0, hex_disp[2]);  // height 005
    check_equal("hex 1", SEG_0, hex_disp[1]);
    check_equal("hex 0", SEG_5, hex_disp[0]);
    close_test();
  endtask

  initial
  begin
    void'($urandom(36277));
    hps_fpga_reset_n = 1'b0;
    vid_in           = '0;
    sw               = '0;
    scdt             = 1'b0;
    sw_set           = '0;
    scdt_set         = 1'b0;
    model_idx        = '0;
    avail            = FIFO_DEPTH;
    test_reset();
    test_heartbeat();
    test_pass_blank();
    test_blend();
    test_pause();
    test_frame();
    $display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
    if (tests_bad == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+tb
rtl/overlay_pkg.sv
rtl/pattern_gen.sv
rtl/pixel_fifo.sv
rtl/overlay_mixer.sv
rtl/board_status.sv
rtl/dvi_overlay_top.sv
tb/tb_dvi_overlay.sv

//--- Bender.yml
package:
  name: dvi_overlay

sources:
  - files:
      - rtl/overlay_pkg.sv
      - rtl/pattern_gen.sv
      - rtl/pixel_fifo.sv
      - rtl/overlay_mixer.sv
      - rtl/board_status.sv
      - rtl/dvi_overlay_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_dvi_overlay.sv
